//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    // cpu load port
    input  logic       cpu_req,
    input  cpu_req_t   cpu_addr,
    output logic       cpu_ack,
    output word_t      cpu_rdata,
    // memory line port
    output logic       mem_req,
    output line_addr_t mem_addr,
    input  logic       mem_ack,
    input  line_t      mem_rdata,
    // main array
    output index_t     rd_index,
    input  tag_t       rd_tag,
    input  logic       rd_valid,
    input  line_t      rd_line,
    output logic       fill_en,
    output line_fill_t fill,
    // victim store
    output line_addr_t lookup_addr,
    input  logic       victim_hit,
    input  line_t      victim_line,
    output logic       push_en,
    output line_fill_t push
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    // request being served and the line it lives in
    cpu_req_t   addr_q;
    line_t      line_q;
    line_addr_t req_line_addr;
    logic       main_hit;

    assign req_line_addr = {addr_q.tag, addr_q.index};
    assign main_hit      = rd_valid && (rd_tag == addr_q.tag);

    assign rd_index    = addr_q.index;
    assign lookup_addr = req_line_addr;
    assign mem_addr    = req_line_addr;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cpu_req) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (main_hit) begin
                    state_nxt = RESP;
                end else if (victim_hit) begin
                    state_nxt = VFILL;
                end else begin
                    state_nxt = MEM_REQ;
                end
            end
            VFILL: begin
                state_nxt = RESP;
            end
            // hold the request until memory answers
            MEM_REQ: begin
                if (mem_ack) begin
                    state_nxt = MEM_DROP;
                end
            end
            // wait for memory to close its side
            MEM_DROP: begin
                if (!mem_ack) begin
                    state_nxt = FILL;
                end
            end
            FILL: begin
                state_nxt = RESP;
            end
            RESP: begin
                if (!cpu_req) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // address latched once per request
    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_req) begin
            addr_q <= cpu_addr;
        end
    end

    // working line from whichever source served the load
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            line_q <= main_hit ? rd_line : victim_line;
        end else if (state == MEM_REQ && mem_ack) begin
            line_q <= mem_rdata;
        end
    end

    assign cpu_ack   = (state == RESP);
    assign cpu_rdata = line_q[addr_q.offset * WORD_W +: WORD_W];
    assign mem_req   = (state == MEM_REQ);

    // refill the main array from the working line
    assign fill_en        = (state == VFILL) || (state == FILL);
    assign fill.line_addr = req_line_addr;
    assign fill.data      = line_q;

    // the line still sitting at this index goes to the victim store
    // in the same cycle, before the fill overwrites it
    assign push_en        = fill_en && rd_valid;
    assign push.line_addr = {rd_tag, rd_index};
    assign push.data      = rd_line;

    // memory closes its side only after the request is gone
    a_mem_ack_after_req: assert property (
        @(posedge clk) disable iff (!rstn)
        $fell(mem_ack) |-> !mem_req
    ) else $error("mem_ack dropped while mem_req still high");

    a_ack_with_req: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(cpu_ack) |-> cpu_req
    ) else $error("cpu_ack raised without cpu_req");

endmodule

//--- dcache_line_store.sv
`timescale 1ns/1ps

module dcache_line_store
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  index_t     rd_index,
    output tag_t       rd_tag,
    output logic       rd_valid,
    output line_t      rd_line,
    input  logic       fill_en,
    input  line_fill_t fill
);

    // direct-mapped arrays
    logic [LINES-1:0] valid;
    tag_t             tag_mem  [LINES];
    line_t            line_mem [LINES];

    // fill target split out of the line address
    index_t wr_index;
    tag_t   wr_tag;

    assign wr_index = fill.line_addr[INDEX_W-1:0];
    assign wr_tag   = fill.line_addr[INDEX_W +: TAG_W];

    // zero latency read
    assign rd_tag   = tag_mem[rd_index];
    assign rd_valid = valid[rd_index];
    assign rd_line  = line_mem[rd_index];

    // valid bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // tag and data
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= fill.data;
        end
    end

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

    // address split: tag | index | word offset | byte
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 4;

    // line and word sizes in bits
    localparam int LINE_W = 512;
    localparam int WORD_W = 32;

    // direct-mapped main array depth
    localparam int LINES = 64;

    // victim store size and its round-robin pointer width
    localparam int VICTIM_ENTRIES = 4;
    localparam int VPTR_W         = 2;

    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [OFFSET_W-1:0]      offset_t;
    // tag followed by index, the key of the victim store
    typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;
    typedef logic [LINE_W-1:0]        line_t;
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [VPTR_W-1:0]        vptr_t;

    // cpu byte address, 32 bits
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [1:0] byte_off;
    } cpu_req_t;

    // one line with its address, used for main array fills and victim pushes
    typedef struct packed {
        line_addr_t line_addr;
        line_t      data;
    } line_fill_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        VFILL,
        MEM_REQ,
        MEM_DROP,
        FILL,
        RESP
    } ctrl_state_t;

endpackage

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       cpu_req,
    input  cpu_req_t   cpu_addr,
    output logic       cpu_ack,
    output word_t      cpu_rdata,
    output logic       mem_req,
    output line_addr_t mem_addr,
    input  logic       mem_ack,
    input  line_t      mem_rdata
);

    // controller to main array
    index_t     rd_index;
    tag_t       rd_tag;
    logic       rd_valid;
    line_t      rd_line;
    logic       fill_en;
    line_fill_t fill;

    // controller to victim store
    line_addr_t lookup_addr;
    logic       victim_hit;
    line_t      victim_line;
    logic       push_en;
    line_fill_t push;

    dcache_ctrl i_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_ack     (cpu_ack),
        .cpu_rdata   (cpu_rdata),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .rd_index    (rd_index),
        .rd_tag      (rd_tag),
        .rd_valid    (rd_valid),
        .rd_line     (rd_line),
        .fill_en     (fill_en),
        .fill        (fill),
        .lookup_addr (lookup_addr),
        .victim_hit  (victim_hit),
        .victim_line (victim_line),
        .push_en     (push_en),
        .push        (push)
    );

    dcache_line_store i_line_store (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .rd_line  (rd_line),
        .fill_en  (fill_en),
        .fill     (fill)
    );

    victim_buffer i_victim (
        .clk         (clk),
        .rstn        (rstn),
        .lookup_addr (lookup_addr),
        .victim_hit  (victim_hit),
        .victim_line (victim_line),
        .push_en     (push_en),
        .push        (push)
    );

endmodule

//--- files.f
dcache_pkg.sv
victim_buffer.sv
dcache_line_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int N_ROWS         = 18;
    localparam int TIMEOUT_CYCLES = N_ROWS * 40;

    // one load: address, expected word, expected memory handshakes so far
    typedef struct packed {
        word_t       addr;
        word_t       exp_word;
        logic [31:0] exp_count;
    } row_t;

    logic       clk = 1'b0;
    logic       rstn;
    logic       cpu_req;
    cpu_req_t   cpu_addr;
    logic       cpu_ack;
    word_t      cpu_rdata;
    logic       mem_req;
    line_addr_t mem_addr;
    logic       mem_ack;
    line_t      mem_rdata;
    int         txn_count;

    row_t rows [N_ROWS];
    int   errors = 0;

    always #2 clk = ~clk;

    dcache_top i_dcache_top (
        .clk       (clk),
        .rstn      (rstn),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    tb_mem_model i_mem_model (
        .clk       (clk),
        .rstn      (rstn),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .txn_count (txn_count)
    );

    task automatic set_row(input int n, input tag_t tag, input index_t index,
                           input offset_t offset, input int count);
        cpu_req_t a;
        a.tag      = tag;
        a.index    = index;
        a.offset   = offset;
        a.byte_off = 2'b00;
        rows[n].addr      = a;
        rows[n].exp_word  = a;
        rows[n].exp_count = count;
    endtask

    // lines A..G share index 5, X sits alone at index 9
    task automatic load_table();
        set_row(0,  20'h1a001, 6'd5, 4'd0,  1);   // A cold miss
        set_row(1,  20'h1a001, 6'd5, 4'd3,  1);   // A main hit
        set_row(2,  20'h2b002, 6'd5, 4'd1,  2);   // B evicts A
        set_row(3,  20'h1a001, 6'd5, 4'd8,  2);   // A from victim
        set_row(4,  20'h3c003, 6'd5, 4'd2,  3);
        set_row(5,  20'h4d004, 6'd5, 4'd4,  4);
        set_row(6,  20'h5e005, 6'd5, 4'd5,  5);
        set_row(7,  20'h6f006, 6'd5, 4'd6,  6);
        set_row(8,  20'h70007, 6'd5, 4'd7,  7);   // buffer now D E F C
        set_row(9,  20'h2b002, 6'd5, 4'd9,  8);   // B was pushed out
        set_row(10, 20'h6f006, 6'd5, 4'd10, 8);   // F still buffered
        set_row(11, 20'h1a001, 6'd5, 4'd11, 9);
        set_row(12, 20'h3c003, 6'd5, 4'd12, 10);
        set_row(13, 20'hfeed1, 6'd9, 4'd0,  11);
        set_row(14, 20'hfeed1, 6'd9, 4'd13, 11);
        set_row(15, 20'h70007, 6'd5, 4'd14, 11);  // G from victim
        set_row(16, 20'h1a001, 6'd5, 4'd15, 11);  // A from victim
        set_row(17, 20'hfeed1, 6'd9, 4'd7,  11);
    endtask

    task automatic apply_row(input int n);
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_addr <= rows[n].addr;
        do begin
            @(posedge clk);
        end while (!cpu_ack);
        assert (cpu_rdata == rows[n].exp_word)
        else begin
            errors++;
            $display("Fail %0t ns: cpu_rdata = %h, expected %h",
                     $time, cpu_rdata, rows[n].exp_word);
        end
        assert (txn_count == rows[n].exp_count)
        else begin
            errors++;
            $display("Fail %0t ns: txn_count = %0d, expected %0d",
                     $time, txn_count, rows[n].exp_count);
        end
        // close the handshake
        cpu_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (cpu_ack);
    endtask

    initial begin : run
        rstn     <= 1'b0;
        cpu_req  <= 1'b0;
        cpu_addr <= '0;
        load_table();
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        assert (cpu_ack == 1'b0)
        else begin
            errors++;
            $display("Fail %0t ns: cpu_ack = %b, expected 0", $time, cpu_ack);
        end
        assert (mem_req == 1'b0)
        else begin
            errors++;
            $display("Fail %0t ns: mem_req = %b, expected 0", $time, mem_req);
        end
        for (int n = 0; n < N_ROWS; n++) begin
            apply_row(n);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles waiting for the cache", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       mem_req,
    input  line_addr_t mem_addr,
    output logic       mem_ack,
    output line_t      mem_rdata,
    output int         txn_count
);

    integer seed = 32'h73b4;

    // word w of line a is its own byte address
    function automatic line_t line_for(line_addr_t a);
        line_t l;
        for (int w = 0; w < LINE_W / WORD_W; w++) begin
            l[w*WORD_W +: WORD_W] = {a, offset_t'(w), 2'b00};
        end
        return l;
    endfunction

    initial begin : serve
        int         delay;
        line_addr_t addr;
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        txn_count <= 0;
        forever begin
            @(posedge clk);
            if (rstn && mem_req && !mem_ack) begin
                addr  = mem_addr;
                // random answer delay of 1 to 8 cycles
                delay = 1 + ($random(seed) & 7);
                repeat (delay) @(posedge clk);
                mem_rdata <= line_for(addr);
                mem_ack   <= 1'b1;
                // hold the line until the controller lets go
                do begin
                    @(posedge clk);
                end while (mem_req);
                mem_ack   <= 1'b0;
                txn_count <= txn_count + 1;
            end
        end
    end

endmodule

//--- victim_buffer.sv
`timescale 1ns/1ps

module victim_buffer
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  line_addr_t lookup_addr,
    output logic       victim_hit,
    output line_t      victim_line,
    input  logic       push_en,
    input  line_fill_t push
);

    // entry storage
    logic [VICTIM_ENTRIES-1:0] valid;
    line_addr_t                addr_mem [VICTIM_ENTRIES];
    line_t                     line_mem [VICTIM_ENTRIES];

    // next entry to overwrite
    vptr_t wr_ptr;

    logic [VICTIM_ENTRIES-1:0] match;
    vptr_t                     hit_sel;

    // compare every valid entry at once
    always_comb begin
        for (int i = 0; i < VICTIM_ENTRIES; i++) begin
            match[i] = valid[i] && (addr_mem[i] == lookup_addr);
        end
    end

    // lowest numbered match wins
    always_comb begin
        hit_sel = '0;
        for (int i = VICTIM_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_sel = vptr_t'(i);
            end
        end
    end

    assign victim_hit  = |match;
    assign victim_line = victim_hit ? line_mem[hit_sel] : '0;

    // round-robin push
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid  <= '0;
            wr_ptr <= '0;
        end else if (push_en) begin
            valid[wr_ptr] <= 1'b1;
            wr_ptr        <= wr_ptr + vptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            addr_mem[wr_ptr] <= push.line_addr;
            line_mem[wr_ptr] <= push.data;
        end
    end

    // the controller drives a single cycle push
    a_push_one_cycle: assert property (
        @(posedge clk) disable iff (!rstn)
        push_en |=> !push_en
    ) else $error("push_en held high for more than one cycle");

    // stale copies can be left behind by a swap, but lines are clean so they
    // must carry the same data as any newer copy of that line
    for (genvar i = 0; i < VICTIM_ENTRIES; i++) begin : g_dup_a
        for (genvar j = i + 1; j < VICTIM_ENTRIES; j++) begin : g_dup_b
            a_dup_same_data: assert property (
                @(posedge clk) disable iff (!rstn)
                (match[i] && match[j]) |-> (line_mem[i] == line_mem[j])
            ) else $error("victim entries %0d and %0d disagree", i, j);
        end
    end

endmodule
